// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_cmp_unit
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
src/ooo_cmp_pkg.sv
src/cmp_dispatch_if.sv
src/branch_cmp.sv
src/result_table.sv
src/cmp_rs.sv
src/cmp_unit_top.sv
testbench/cmp_unit_sva.sv
testbench/tb_cmp_unit.sv

// File: src/branch_cmp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational RV32I comparator.
// Branch codes give the taken condition, slt/sltu the less-than bit.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module branch_cmp (
    input  ooo_cmp_pkg::word_t   a,
    input  ooo_cmp_pkg::word_t   b,
    input  ooo_cmp_pkg::cmp_op_t op,
    output logic                 taken
);
    import ooo_cmp_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (op)
            beq:     taken = eq;
            bne:     taken = !eq;
            blt:     taken = lt_s;
            bge:     taken = !lt_s;
            bltu:    taken = lt_u;
            bgeu:    taken = !lt_u;
            slt:     taken = lt_s;      // same signed order as blt
            sltu:    taken = lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: src/cmp_dispatch_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dispatch link into the comparator station.
// One micro-op moves on a rising edge with valid and ready high.
// The sender must hold every field stable until it is accepted.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface cmp_dispatch_if;
    import ooo_cmp_pkg::*;

    logic    valid;
    logic    ready;             // high while any station entry is free
    logic    is_br;
    cmp_op_t op;
    word_t   vj;                // operand values, used when the tag is 0
    word_t   vk;
    tag_t    qj;                // producer tags, 0 means no dependency
    tag_t    qk;
    tag_t    dest;
    logic    br_pred;           // predicted taken
    word_t   pc;
    word_t   b_imm;             // sign-extended branch offset

    modport sender (
        output valid, is_br, op, vj, vk, qj, qk, dest, br_pred, pc, b_imm,
        input  ready
    );

    modport station (
        input  valid, is_br, op, vj, vk, qj, qk, dest, br_pred, pc, b_imm,
        output ready
    );

endinterface

// File: src/cmp_rs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Comparator reservation station with one comparator per entry.
// The lowest free entry takes a dispatch. Busy entries pick up
// operands from the result table one edge after their tag is ready.
// A complete entry drives its own lane for one cycle and frees up
// on the same edge, so lanes never wait and there is no arbiter.
// NUM_ENTRIES may be 1 to 8.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cmp_rs #(
    parameter int NUM_ENTRIES = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    cmp_dispatch_if.station        disp,
    input  logic                   tag_ready [ooo_cmp_pkg::NUM_TAGS],
    input  ooo_cmp_pkg::word_t     tag_val   [ooo_cmp_pkg::NUM_TAGS],
    output ooo_cmp_pkg::cmp_lane_t lanes     [NUM_ENTRIES]
);
    import ooo_cmp_pkg::*;

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    // entry storage
    logic    busy    [NUM_ENTRIES];
    logic    is_br   [NUM_ENTRIES];
    cmp_op_t op      [NUM_ENTRIES];
    word_t   vj      [NUM_ENTRIES];
    word_t   vk      [NUM_ENTRIES];
    tag_t    qj      [NUM_ENTRIES];
    tag_t    qk      [NUM_ENTRIES];
    tag_t    dest    [NUM_ENTRIES];
    logic    br_pred [NUM_ENTRIES];
    word_t   pc      [NUM_ENTRIES];
    word_t   b_imm   [NUM_ENTRIES];

    logic             free_any;
    logic [IDX_W-1:0] free_idx;
    logic             take;
    logic             issue [NUM_ENTRIES];
    logic             taken [NUM_ENTRIES];

    // registered lane state
    logic  lane_valid   [NUM_ENTRIES];
    logic  lane_is_br   [NUM_ENTRIES];
    tag_t  lane_tag     [NUM_ENTRIES];
    word_t lane_val     [NUM_ENTRIES];
    word_t lane_pc_next [NUM_ENTRIES];
    logic  lane_pred_ok [NUM_ENTRIES];

    // walk down so the lowest free index is the one that sticks
    always_comb begin
        free_any = 1'b0;
        free_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_any = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    assign disp.ready = free_any;
    assign take       = disp.valid && free_any;

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            issue[i] = busy[i] && (qj[i] == '0) && (qk[i] == '0);
        end
    end

    for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_cmp
        branch_cmp i_branch_cmp (
            .a     (vj[g]),
            .b     (vk[g]),
            .op    (op[g]),
            .taken (taken[g])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                busy[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (issue[i]) begin
                    busy[i] <= 1'b0;    // result goes out on this edge
                end else if (take && free_idx == IDX_W'(i)) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

    // load on transfer, otherwise wake up pending operands
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (take && free_idx == IDX_W'(i)) begin
                is_br[i]   <= disp.is_br;
                op[i]      <= disp.op;
                vj[i]      <= disp.vj;
                vk[i]      <= disp.vk;
                qj[i]      <= disp.qj;
                qk[i]      <= disp.qk;
                dest[i]    <= disp.dest;
                br_pred[i] <= disp.br_pred;
                pc[i]      <= disp.pc;
                b_imm[i]   <= disp.b_imm;
            end else if (busy[i]) begin
                if (qj[i] != '0 && tag_ready[qj[i]]) begin
                    vj[i] <= tag_val[qj[i]];
                    qj[i] <= '0;
                end
                if (qk[i] != '0 && tag_ready[qk[i]]) begin
                    vk[i] <= tag_val[qk[i]];
                    qk[i] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                lane_valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                lane_valid[i] <= issue[i];   // one-cycle pulse per entry
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (issue[i]) begin
                lane_is_br[i]   <= is_br[i];
                lane_tag[i]     <= dest[i];
                lane_val[i]     <= {31'd0, taken[i]};
                lane_pc_next[i] <= taken[i] ? (pc[i] + b_imm[i]) : (pc[i] + 32'd4);
                lane_pred_ok[i] <= (br_pred[i] == taken[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            lanes[i].valid   = lane_valid[i];
            lanes[i].is_br   = lane_is_br[i];
            lanes[i].tag     = lane_tag[i];
            lanes[i].val     = lane_val[i];
            lanes[i].pc_next = lane_pc_next[i];
            lanes[i].pred_ok = lane_pred_ok[i];
        end
    end

endmodule

// File: src/cmp_unit_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Comparator issue cluster with plain ports.
// Results leave as packed vectors with one slice per station lane.
// They are never stalled, so a consumer must sample every lane on
// each cycle that its res_valid bit is high.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cmp_unit_top #(
    parameter int NUM_ENTRIES = 3
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   flush,
    input  logic                                   disp_valid,
    input  logic                                   disp_is_br,
    input  ooo_cmp_pkg::cmp_op_t                   disp_op,
    input  ooo_cmp_pkg::word_t                     disp_vj,
    input  ooo_cmp_pkg::word_t                     disp_vk,
    input  ooo_cmp_pkg::tag_t                      disp_qj,
    input  ooo_cmp_pkg::tag_t                      disp_qk,
    input  ooo_cmp_pkg::tag_t                      disp_dest,
    input  logic                                   disp_br_pred,
    input  ooo_cmp_pkg::word_t                     disp_pc,
    input  ooo_cmp_pkg::word_t                     disp_b_imm,
    output logic                                   disp_ready,
    input  logic                                   wb_valid,
    input  ooo_cmp_pkg::tag_t                      wb_tag,
    input  ooo_cmp_pkg::word_t                     wb_val,
    output logic               [NUM_ENTRIES-1:0]   res_valid,
    output logic               [NUM_ENTRIES-1:0]   res_is_br,
    output ooo_cmp_pkg::tag_t  [NUM_ENTRIES-1:0]   res_tag,
    output ooo_cmp_pkg::word_t [NUM_ENTRIES-1:0]   res_val,
    output ooo_cmp_pkg::word_t [NUM_ENTRIES-1:0]   res_pc_next,
    output logic               [NUM_ENTRIES-1:0]   res_pred_ok
);
    import ooo_cmp_pkg::*;

    cmp_dispatch_if disp_if ();

    logic      tag_ready [NUM_TAGS];
    word_t     tag_val   [NUM_TAGS];
    cmp_lane_t lanes     [NUM_ENTRIES];

    assign disp_if.valid   = disp_valid;
    assign disp_if.is_br   = disp_is_br;
    assign disp_if.op      = disp_op;
    assign disp_if.vj      = disp_vj;
    assign disp_if.vk      = disp_vk;
    assign disp_if.qj      = disp_qj;
    assign disp_if.qk      = disp_qk;
    assign disp_if.dest    = disp_dest;
    assign disp_if.br_pred = disp_br_pred;
    assign disp_if.pc      = disp_pc;
    assign disp_if.b_imm   = disp_b_imm;
    assign disp_ready      = disp_if.ready;

    cmp_rs #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_cmp_rs (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .disp      (disp_if.station),
        .tag_ready (tag_ready),
        .tag_val   (tag_val),
        .lanes     (lanes)
    );

    result_table #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_result_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .alloc     (disp_if.valid && disp_if.ready),   // dispatch transfer
        .alloc_tag (disp_if.dest),
        .wb_valid  (wb_valid),
        .wb_tag    (wb_tag),
        .wb_val    (wb_val),
        .lanes     (lanes),
        .tag_ready (tag_ready),
        .tag_val   (tag_val)
    );

    for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_res
        assign res_valid[g]   = lanes[g].valid;
        assign res_is_br[g]   = lanes[g].is_br;
        assign res_tag[g]     = lanes[g].tag;
        assign res_val[g]     = lanes[g].val;
        assign res_pc_next[g] = lanes[g].pc_next;
        assign res_pred_ok[g] = lanes[g].pred_ok;
    end

endmodule

// File: src/ooo_cmp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the comparator issue cluster.
// Tags are TAG_W bits wide. Tag 0 is reserved and means the
// operand value is already present, so only tags 1 to 7 are real
// producers. The compare op codes follow RV32I branch funct3, and
// slt/sltu sit in the two codes that branches leave unused.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ooo_cmp_pkg;

    localparam int TAG_W    = 3;
    localparam int NUM_TAGS = 1 << TAG_W;

    typedef logic [31:0]      word_t;
    typedef logic [TAG_W-1:0] tag_t;

    // branch funct3 values, with the two holes reused for set-less-than
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        slt  = 3'b010,          // unused by branches in RV32I
        sltu = 3'b011,          // unused by branches in RV32I
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    // one registered result lane of the station
    typedef struct packed {
        logic  valid;           // high for one cycle per completed entry
        logic  is_br;           // branch results never go to the table
        tag_t  tag;             // destination tag of the micro-op
        word_t val;             // 0/1 compare result, zero-extended
        word_t pc_next;         // resolved target or fall-through
        logic  pred_ok;         // the prediction matched the outcome
    } cmp_lane_t;

endpackage

// File: src/result_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tag-indexed ready bits and values, a stand-in for the ROB store.
// Write priority per tag is writeback, then lane result, then the
// dispatch clear. Tag 0 always reads ready with a zero value.
// Flush marks every tag ready but leaves stored values alone.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module result_table #(
    parameter int NUM_ENTRIES = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   alloc,
    input  ooo_cmp_pkg::tag_t      alloc_tag,
    input  logic                   wb_valid,
    input  ooo_cmp_pkg::tag_t      wb_tag,
    input  ooo_cmp_pkg::word_t     wb_val,
    input  ooo_cmp_pkg::cmp_lane_t lanes     [NUM_ENTRIES],
    output logic                   tag_ready [ooo_cmp_pkg::NUM_TAGS],
    output ooo_cmp_pkg::word_t     tag_val   [ooo_cmp_pkg::NUM_TAGS]
);
    import ooo_cmp_pkg::*;

    logic  ready_q  [1:NUM_TAGS-1];
    word_t val_q    [1:NUM_TAGS-1];
    logic  lane_hit [1:NUM_TAGS-1];
    word_t lane_val [1:NUM_TAGS-1];

    // collect the compare lanes that target each tag
    always_comb begin
        for (int t = 1; t < NUM_TAGS; t++) begin
            lane_hit[t] = 1'b0;
            lane_val[t] = '0;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (lanes[i].valid && !lanes[i].is_br && lanes[i].tag == tag_t'(t)) begin
                    lane_hit[t] = 1'b1;
                    lane_val[t] = lanes[i].val;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int t = 1; t < NUM_TAGS; t++) begin
                ready_q[t] <= 1'b1;
            end
        end else begin
            for (int t = 1; t < NUM_TAGS; t++) begin
                if (wb_valid && wb_tag == tag_t'(t)) begin
                    ready_q[t] <= 1'b1;
                end else if (lane_hit[t]) begin
                    ready_q[t] <= 1'b1;
                end else if (alloc && alloc_tag == tag_t'(t)) begin
                    ready_q[t] <= 1'b0;     // a new producer is in flight
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int t = 1; t < NUM_TAGS; t++) begin
            if (wb_valid && wb_tag == tag_t'(t)) begin
                val_q[t] <= wb_val;
            end else if (lane_hit[t]) begin
                val_q[t] <= lane_val[t];
            end
        end
    end

    always_comb begin
        tag_ready[0] = 1'b1;                // no dependency is always satisfied
        tag_val[0]   = '0;
        for (int t = 1; t < NUM_TAGS; t++) begin
            tag_ready[t] = ready_q[t];
            tag_val[t]   = val_q[t];
        end
    end

endmodule

// File: testbench/cmp_unit_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dispatch and result-pulse properties of cmp_unit_top.
// Bound into the top level, lane pulses are only checked out of reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module cmp_unit_sva #(
    parameter int NUM_ENTRIES = 3
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   flush,
    input logic                   disp_ready,
    input logic [NUM_ENTRIES-1:0] res_valid
);

    // an emptied station takes a dispatch at once and broadcasts nothing
    a_clear_state : assert property (@(posedge clk)
        (!rst_n || flush) |=> (disp_ready && res_valid == '0))
        else $error("station is not empty in the cycle after reset or flush");

    for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_lane
        a_single_pulse : assert property (@(posedge clk) disable iff (!rst_n)
            res_valid[g] |=> !res_valid[g])
            else $error("res_valid[%0d] stayed high for two cycles", g);
    end

endmodule

bind cmp_unit_top cmp_unit_sva #(.NUM_ENTRIES(NUM_ENTRIES)) i_cmp_unit_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .disp_ready (disp_ready),
    .res_valid  (res_valid)
);

// File: testbench/tb_cmp_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for cmp_unit_top with three station entries.
// Inputs change 10 ns after a rising edge and outputs are read there.
// Results are matched to micro-ops by destination tag, so tags that
// are in flight together must differ.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_cmp_unit;
    import ooo_cmp_pkg::*;

    localparam int NE      = 3;
    localparam int TIMEOUT = 40;

    logic    clk          = 1'b0;
    logic    rst_n        = 1'b0;
    logic    flush        = 1'b0;
    logic    wb_valid     = 1'b0;
    logic    disp_valid   = 1'b0;
    logic    disp_is_br   = 1'b0;
    logic    disp_br_pred = 1'b0;
    logic    disp_ready;
    cmp_op_t disp_op      = beq;
    word_t   disp_vj      = '0;
    word_t   disp_vk      = '0;
    word_t   disp_pc      = '0;
    word_t   disp_b_imm   = '0;
    word_t   wb_val       = '0;
    tag_t    disp_qj      = '0;
    tag_t    disp_qk      = '0;
    tag_t    disp_dest    = '0;
    tag_t    wb_tag       = '0;
    logic  [NE-1:0] res_valid, res_is_br, res_pred_ok;
    tag_t  [NE-1:0] res_tag;
    word_t [NE-1:0] res_val, res_pc_next;
    int      errors = 0;
    int      timeouts = 0;

    cmp_unit_top #(.NUM_ENTRIES(NE)) i_cmp_unit_top (.*);

    always #50 clk = ~clk;

    task automatic next_cycle;
        @(posedge clk);
        #10;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // signed order is the unsigned order with both sign bits flipped
    function automatic logic ref_taken(input cmp_op_t op, input word_t a, input word_t b);
        logic lt_s;
        lt_s = ({~a[31], a[30:0]} < {~b[31], b[30:0]});
        case (op)
            beq:        return a == b;
            bne:        return a != b;
            blt, slt:   return lt_s;
            bge:        return !lt_s;
            bltu, sltu: return a < b;
            default:    return a >= b;      // bgeu
        endcase
    endfunction

    task automatic dispatch(input logic br, input cmp_op_t op, input word_t vj, input word_t vk,
                            input tag_t qj, input tag_t qk, input tag_t dest, input logic pred,
                            input word_t pc, input word_t imm);
        int n;
        n            = 0;
        disp_valid   = 1'b1;
        disp_is_br   = br;
        disp_op      = op;
        disp_vj      = vj;
        disp_vk      = vk;
        disp_qj      = qj;
        disp_qk      = qk;
        disp_dest    = dest;
        disp_br_pred = pred;
        disp_pc      = pc;
        disp_b_imm   = imm;
        while (!disp_ready && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!disp_ready) begin
            timeouts++;
            $display("timeout at %0t ns: dispatch to tag %0d was never accepted", $time, dest);
        end
        next_cycle();                       // transfer edge
        disp_valid = 1'b0;
    endtask

    task automatic writeback(input tag_t tag, input word_t val);
        wb_valid = 1'b1;
        wb_tag   = tag;
        wb_val   = val;
        next_cycle();
        wb_valid = 1'b0;
    endtask

    task automatic wait_result(input tag_t tag, output cmp_lane_t lane, output int waited);
        lane   = '0;
        waited = 0;
        while (!lane.valid && waited <= TIMEOUT) begin
            for (int i = 0; i < NE; i++) begin
                if (res_valid[i] && res_tag[i] == tag) begin
                    lane = '{1'b1, res_is_br[i], res_tag[i], res_val[i],
                             res_pc_next[i], res_pred_ok[i]};
                end
            end
            if (!lane.valid) begin
                next_cycle();
                waited++;
            end
        end
        if (!lane.valid) begin
            timeouts++;
            $display("timeout at %0t ns: no result arrived for tag %0d", $time, tag);
        end
    endtask

    // lat of 0 leaves the latency unchecked
    task automatic expect_result(input tag_t tag, input logic br, input cmp_op_t op,
                                 input word_t a, input word_t b, input logic pred,
                                 input word_t pc, input word_t imm, input int lat);
        cmp_lane_t lane;
        int        waited;
        logic      taken;
        taken = ref_taken(op, a, b);
        wait_result(tag, lane, waited);
        if (lane.valid) begin
            check("res_is_br", 32'(lane.is_br), 32'(br));
            if (br) begin
                check("res_pc_next", lane.pc_next, taken ? pc + imm : pc + 32'd4);
                check("res_pred_ok", 32'(lane.pred_ok), 32'(pred == taken));
            end else begin
                check("res_val", lane.val, 32'(taken));
            end
            if (lat > 0) begin
                check("result latency", 32'(waited), 32'(lat));
            end
        end
    endtask

    // a branch result never reaches the table, so its tag stays pending
    task automatic reserve_tag(input tag_t tag);
        cmp_lane_t lane;
        int        waited;
        dispatch(1'b1, beq, '0, '0, '0, '0, tag, 1'b1, '0, '0);
        wait_result(tag, lane, waited);
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            check("res_valid", 32'(res_valid), '0);
            next_cycle();
        end
    endtask

    task automatic ready_operands;
        cmp_op_t op;
        word_t   a, b, rnd;
        logic    br, pred;
        for (int k = 0; k < 16; k++) begin
            op   = cmp_op_t'(k[3:1]);
            br   = (op != slt) && (op != sltu);
            a    = $urandom;
            b    = k[0] ? a : $urandom;     // every op also sees equal operands
            pred = 1'($urandom);
            rnd  = $urandom;
            dispatch(br, op, a, b, '0, '0, 3'd7, pred, {rnd[31:2], 2'b00},
                     {{19{rnd[12]}}, rnd[12:1], 1'b0});
            expect_result(3'd7, br, op, a, b, pred, {rnd[31:2], 2'b00},
                          {{19{rnd[12]}}, rnd[12:1], 1'b0}, 1);
        end
    endtask

    task automatic operand_wakeup;
        word_t x, y, k;
        x = $urandom & 32'h7fff_ffff;       // below k, so only the written x gives 1
        y = $urandom;
        k = $urandom | 32'h8000_0000;
        reserve_tag(3'd1);
        reserve_tag(3'd2);
        dispatch(1'b0, sltu, 32'hffff_ffff, k, 3'd1, '0, 3'd3, 1'b0, '0, '0);
        dispatch(1'b1, blt, '0, '0, 3'd1, 3'd2, 3'd4, 1'b1, 32'h100, 32'h40);
        check_quiet(4);
        writeback(3'd1, x);
        expect_result(3'd3, 1'b0, sltu, x, k, 1'b0, '0, '0, 0);
        writeback(3'd2, y);
        expect_result(3'd4, 1'b1, blt, x, y, 1'b1, 32'h100, 32'h40, 0);
    endtask

    task automatic chained_dependence;
        word_t a, b;
        logic  pred;
        a    = $urandom;
        b    = $urandom;
        pred = 1'($urandom);
        reserve_tag(3'd4);
        dispatch(1'b0, slt, a, '0, '0, 3'd4, 3'd5, 1'b0, '0, '0);
        dispatch(1'b1, bne, '0, '0, 3'd5, '0, 3'd6, pred, 32'h800, 32'hffff_fff0);
        check_quiet(3);
        writeback(3'd4, b);
        expect_result(3'd5, 1'b0, slt, a, b, 1'b0, '0, '0, 0);
        expect_result(3'd6, 1'b1, bne, 32'(ref_taken(slt, a, b)), '0, pred,
                      32'h800, 32'hffff_fff0, 0);
    endtask

    task automatic full_station_stall;
        word_t a, b, x;
        a = $urandom;
        b = $urandom;
        x = $urandom;
        reserve_tag(3'd1);
        reserve_tag(3'd2);
        reserve_tag(3'd3);
        dispatch(1'b0, sltu, '0, a, 3'd1, '0, 3'd4, 1'b0, '0, '0);
        dispatch(1'b0, slt, b, '0, '0, 3'd2, 3'd5, 1'b0, '0, '0);
        dispatch(1'b1, bgeu, a, '0, '0, 3'd3, 3'd6, 1'b0, 32'h2000, 32'h8);
        fork
            dispatch(1'b0, sltu, a, b, '0, '0, 3'd7, 1'b0, '0, '0);
            begin
                repeat (3) begin
                    check("disp_ready", 32'(disp_ready), '0);
                    next_cycle();
                end
                writeback(3'd1, x);
                expect_result(3'd4, 1'b0, sltu, x, a, 1'b0, '0, '0, 0);
            end
        join
        expect_result(3'd7, 1'b0, sltu, a, b, 1'b0, '0, '0, 1);
        writeback(3'd2, x);
        expect_result(3'd5, 1'b0, slt, b, x, 1'b0, '0, '0, 0);
        writeback(3'd3, b);
        expect_result(3'd6, 1'b1, bgeu, a, b, 1'b0, 32'h2000, 32'h8, 0);
    endtask

    task automatic flush_pending;
        word_t a, b;
        a = $urandom;
        b = $urandom;
        reserve_tag(3'd1);
        reserve_tag(3'd2);
        dispatch(1'b0, slt, '0, b, 3'd1, '0, 3'd3, 1'b0, '0, '0);
        dispatch(1'b1, beq, a, '0, '0, 3'd2, 3'd4, 1'b1, 32'h40, 32'h10);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        check("disp_ready", 32'(disp_ready), 32'd1);
        writeback(3'd1, a);
        writeback(3'd2, b);
        check_quiet(5);
        // the flushed table reads tag 1 as ready with the value just written
        dispatch(1'b0, sltu, '0, b, 3'd1, '0, 3'd5, 1'b0, '0, '0);
        expect_result(3'd5, 1'b0, sltu, a, b, 1'b0, '0, '0, 0);
    endtask

    initial begin
        void'($urandom(32'hf56bae88));
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check("disp_ready", 32'(disp_ready), 32'd1);
        ready_operands();
        operand_wakeup();
        chained_dependence();
        full_station_stall();
        flush_pending();
        $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
